// ==== Bender.yml ====
package:
  name: gemm_tile

sources:
  - files:
      - verilog/gemm_pkg.sv
      - verilog/tile_buffer.sv
      - verilog/mm_engine.sv
      - verilog/dma_engine.sv
      - verilog/gemm_top.sv
  - target: test
    files:
      - verification/gemm_top_sva.sv
      - verification/tb_gemm_top.sv

// ==== files.f ====
verilog/gemm_pkg.sv
verilog/tile_buffer.sv
verilog/mm_engine.sv
verilog/dma_engine.sv
verilog/gemm_top.sv
verification/gemm_top_sva.sv
verification/tb_gemm_top.sv

// ==== verification/gemm_top_sva.sv ====
// assertions bound to gemm_top
// AXI valid hold, multiply start pulse, write response against done
`timescale 1ns/1ps

module gemm_top_sva
    import gemm_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input logic      arvalid_o,
    input logic      arready_i,
    input axi_addr_t araddr_o,
    input logic      wvalid_o,
    input logic      wready_i,
    input word_t     wdata_o,
    input logic      mm_start,
    input logic      bready_o,
    input logic      done_o
);

    // failed assertions so far
    int unsigned fail_cnt = 0;

    // read address held until accepted
    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o))
        else begin
            $error("read address dropped or changed before arready");
            fail_cnt++;
        end

    // write data held until accepted
    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid_o && !wready_i |=> wvalid_o && $stable(wdata_o))
        else begin
            $error("write data dropped or changed before wready");
            fail_cnt++;
        end

    start_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        mm_start |=> !mm_start)
        else begin
            $error("multiply start longer than one cycle");
            fail_cnt++;
        end

    // no response wait while idle
    b_not_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !(bready_o && done_o))
        else begin
            $error("bready high while done is high");
            fail_cnt++;
        end

endmodule

bind gemm_top gemm_top_sva u_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .arvalid_o (arvalid_o),
    .arready_i (arready_i),
    .araddr_o  (araddr_o),
    .wvalid_o  (wvalid_o),
    .wready_i  (wready_i),
    .wdata_o   (wdata_o),
    .mm_start  (mm_start),
    .bready_o  (bready_o),
    .done_o    (done_o)
);

// ==== verification/tb_gemm_top.sv ====
// testbench for the gemm tile accelerator
// clock, reset, AXI memory model with random stalls
// reference model of C and comparison of the written beats
`timescale 1ns/1ps

module tb_gemm_top
    import gemm_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int RST_CYCLES   = 8;
    localparam int NUM_JOBS     = 6;
    localparam int DONE_TIMEOUT = 2000;
    localparam int MEM_WORDS    = 1024;

    logic      clk;
    logic      rst_n;
    axi_addr_t mat_a_addr_i;
    axi_addr_t mat_b_addr_i;
    axi_addr_t mat_c_addr_i;
    logic      start_i;
    logic      done_o;
    logic      arvalid_o;
    logic      arready_i;
    axi_addr_t araddr_o;
    axi_id_t   arid_o;
    logic      rvalid_i;
    logic      rready_o;
    axi_id_t   rid_i;
    word_t     rdata_i;
    logic      awvalid_o;
    logic      awready_i;
    axi_addr_t awaddr_o;
    logic      wvalid_o;
    logic      wready_i;
    word_t     wdata_o;
    logic      wlast_o;
    logic      bvalid_i;
    logic      bready_o;

    // word-addressed 4 KB memory window
    word_t       mem [MEM_WORDS];
    logic [31:0] lcg_state;
    bit          stall_en;
    int          a_mat [SA_WIDTH][SA_WIDTH];
    int          b_mat [SA_WIDTH][SA_WIDTH];

    // transfers seen by the memory model over all jobs in order
    axi_addr_t   ar_addr_q [$];
    axi_id_t     ar_id_q   [$];
    axi_addr_t   aw_addr_q [$];
    word_t       wbeat_q   [$];
    logic        wlast_q   [$];
    int unsigned b_cnt;

    int unsigned check_cnt;
    int unsigned error_cnt;
    int unsigned timeout_cnt;

    gemm_top DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .mat_a_addr_i (mat_a_addr_i),
        .mat_b_addr_i (mat_b_addr_i),
        .mat_c_addr_i (mat_c_addr_i),
        .start_i      (start_i),
        .done_o       (done_o),
        .arvalid_o    (arvalid_o),
        .arready_i    (arready_i),
        .araddr_o     (araddr_o),
        .arid_o       (arid_o),
        .rvalid_i     (rvalid_i),
        .rready_o     (rready_o),
        .rid_i        (rid_i),
        .rdata_i      (rdata_i),
        .awvalid_o    (awvalid_o),
        .awready_i    (awready_i),
        .awaddr_o     (awaddr_o),
        .wvalid_o     (wvalid_o),
        .wready_i     (wready_i),
        .wdata_o      (wdata_o),
        .wlast_o      (wlast_o),
        .bvalid_i     (bvalid_i),
        .bready_o     (bready_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // LCG step returning the upper state bits
    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    function automatic logic [31:0] rand_word();
        logic [15:0] hi;
        logic [15:0] lo;
        hi = next_rand();
        lo = next_rand();
        return {hi, lo};
    endfunction

    // mostly random with some extreme values
    function automatic word_t rand_elem();
        logic [3:0] sel;
        sel = 4'(next_rand());
        case (sel)
            4'h0: return 32'h8000_0000;
            4'h1: return 32'h7fff_ffff;
            4'h2: return 32'hffff_ffff;
            default: return rand_word();
        endcase
    endfunction

    function automatic int pick_delay(input int max_wait);
        if (!stall_en) begin
            return 0;
        end
        return next_rand() % (max_wait + 1);
    endfunction

    // C[i][j] as the low 32 bits of the sum over k of A[i][k] * B[k][j]
    function automatic word_t ref_c(input int i, input int j);
        longint acc;
        acc = 0;
        for (int k = 0; k < SA_WIDTH; k++) begin
            acc += longint'(a_mat[i][k]) * longint'(b_mat[k][j]);
        end
        return acc[DW-1:0];
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("FAIL @ %0t: %s, got 0x%0h expected 0x%0h", $time, what, got, exp);
        end
    endtask

    // one ready decision for a DUT-driven valid
    task automatic ready_step(input logic valid, input int max_wait, inout int wait_cnt,
                              inout bit armed, output logic ready);
        ready = 1'b0;
        if (valid) begin
            if (!armed) begin
                wait_cnt = pick_delay(max_wait);
                armed    = 1'b1;
            end
            if (wait_cnt == 0) begin
                ready = 1'b1;
                armed = 1'b0;
            end else begin
                wait_cnt--;
            end
        end
    endtask

    // three distinct 64-byte slots with A column-major and B row-major
    task automatic load_job();
        int slot_a;
        int slot_b;
        int slot_c;
        slot_a = next_rand() % 64;
        slot_b = (slot_a + 1 + next_rand() % 21) % 64;
        slot_c = (slot_a + 22 + next_rand() % 21) % 64;
        mat_a_addr_i = {next_rand(), 4'h1, 6'(slot_a), 6'h00};
        mat_b_addr_i = {next_rand(), 4'h2, 6'(slot_b), 6'h00};
        mat_c_addr_i = {next_rand(), 4'h3, 6'(slot_c), 6'h00};
        for (int i = 0; i < SA_WIDTH; i++) begin
            for (int k = 0; k < SA_WIDTH; k++) begin
                a_mat[i][k] = rand_elem();
                b_mat[i][k] = rand_elem();
                mem[slot_a * 16 + k * SA_WIDTH + i] = a_mat[i][k];
                mem[slot_b * 16 + i * SA_WIDTH + k] = b_mat[i][k];
            end
        end
    endtask

    task automatic run_job(input int job, output bit ok);
        int cycles;
        @(negedge clk);
        start_i = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
        check_value("done_o after start", done_o, 1'b0);
        check_value("arvalid_o after start", arvalid_o, 1'b1);
        cycles = 0;
        while (!done_o && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!done_o) begin
            timeout_cnt++;
            ok = 1'b0;
            $display("timeout: job %0d did not raise done_o within %0d cycles", job, cycles);
        end else begin
            ok = 1'b1;
            // done may only rise with the write response
            check_value("write responses at done", b_cnt, job + 1);
            @(negedge clk);
            check_value("done_o held after job", done_o, 1'b1);
        end
    endtask

    task automatic compare_job(input int job);
        int base;
        base = BURST_BEATS * job;
        check_value("read address count", ar_addr_q.size(), 2 * (job + 1));
        check_value("write address count", aw_addr_q.size(), job + 1);
        check_value("write beat count", wbeat_q.size(), base + BURST_BEATS);
        if (ar_addr_q.size() >= 2 * (job + 1)) begin
            check_value("first read address", ar_addr_q[2 * job], mat_a_addr_i);
            check_value("first read id", ar_id_q[2 * job], ID_A);
            check_value("second read address", ar_addr_q[2 * job + 1], mat_b_addr_i);
            check_value("second read id", ar_id_q[2 * job + 1], ID_B);
        end
        if (aw_addr_q.size() >= job + 1) begin
            check_value("write address", aw_addr_q[job], mat_c_addr_i);
        end
        for (int n = 0; n < BURST_BEATS; n++) begin
            if (base + n < wbeat_q.size()) begin
                check_value($sformatf("job %0d C[%0d][%0d]", job, n / SA_WIDTH, n % SA_WIDTH),
                            wbeat_q[base + n], ref_c(n / SA_WIDTH, n % SA_WIDTH));
                check_value($sformatf("job %0d wlast on beat %0d", job, n),
                            wlast_q[base + n], n == BURST_BEATS - 1);
            end
        end
    endtask

    // memory model deciding every handshake on the falling edge
    initial begin : mem_model
        int ar_wait;
        int aw_wait;
        int w_wait;
        int b_wait;
        bit ar_armed;
        bit aw_armed;
        bit w_armed;
        bit r_go;
        bit b_go;
        bit b_pend;
        int rd_base [2];
        int rd_cnt  [2];
        int aw_base;
        int w_cnt;
        int id;
        int n_act;
        arready_i = 1'b0;
        rvalid_i  = 1'b0;
        rid_i     = '0;
        rdata_i   = '0;
        awready_i = 1'b0;
        wready_i  = 1'b0;
        bvalid_i  = 1'b0;
        b_cnt     = 0;
        ar_wait   = 0;
        aw_wait   = 0;
        w_wait    = 0;
        b_wait    = 0;
        ar_armed  = 1'b0;
        aw_armed  = 1'b0;
        w_armed   = 1'b0;
        r_go      = 1'b0;
        b_go      = 1'b0;
        b_pend    = 1'b0;
        aw_base   = 0;
        w_cnt     = 0;
        id        = 0;
        // no burst open
        rd_cnt[0] = BURST_BEATS;
        rd_cnt[1] = BURST_BEATS;
        rd_base[0] = 0;
        rd_base[1] = 0;
        forever begin
            @(negedge clk);
            // R handled before AR so data starts the cycle after its address
            if (r_go) begin
                rd_cnt[rid_i] = rd_cnt[rid_i] + 1;
                rvalid_i = 1'b0;
            end
            if (!rvalid_i) begin
                n_act = 0;
                for (int i = 0; i < 2; i++) begin
                    if (rd_cnt[i] < BURST_BEATS) begin
                        n_act++;
                        id = i;
                    end
                end
                // random interleave of A and B beats
                if (n_act == 2) begin
                    id = next_rand() % 2;
                end
                // under stalls one slot in four stays idle
                if (n_act > 0 && pick_delay(3) < 3) begin
                    rvalid_i = 1'b1;
                    rid_i    = axi_id_t'(id);
                    rdata_i  = mem[rd_base[id] + rd_cnt[id]];
                end
            end
            r_go = rvalid_i && rready_o;

            ready_step(arvalid_o, 3, ar_wait, ar_armed, arready_i);
            if (arvalid_o && arready_i) begin
                ar_addr_q.push_back(araddr_o);
                ar_id_q.push_back(arid_o);
                rd_base[arid_o] = araddr_o[11:2];
                rd_cnt[arid_o]  = 0;
            end

            ready_step(awvalid_o, 4, aw_wait, aw_armed, awready_i);
            if (awvalid_o && awready_i) begin
                aw_addr_q.push_back(awaddr_o);
                aw_base = awaddr_o[11:2];
                w_cnt   = 0;
            end

            // B handled before W so the response follows the last write beat
            if (b_go) begin
                bvalid_i = 1'b0;
                b_pend   = 1'b0;
            end else if (b_pend && !bvalid_i) begin
                if (b_wait == 0) begin
                    bvalid_i = 1'b1;
                end else begin
                    b_wait--;
                end
            end
            b_go = bvalid_i && bready_o;
            if (b_go) begin
                b_cnt++;
            end

            ready_step(wvalid_o, 2, w_wait, w_armed, wready_i);
            if (wvalid_o && wready_i) begin
                wbeat_q.push_back(wdata_o);
                wlast_q.push_back(wlast_o);
                if (w_cnt < BURST_BEATS) begin
                    mem[aw_base + w_cnt] = wdata_o;
                end
                w_cnt++;
                if (wlast_o) begin
                    b_pend = 1'b1;
                    b_wait = pick_delay(3);
                end
            end
        end
    end

    initial begin : main_seq
        bit ok;
        lcg_state    = 32'd79;
        check_cnt    = 0;
        error_cnt    = 0;
        timeout_cnt  = 0;
        stall_en     = 1'b0;
        rst_n        = 1'b0;
        start_i      = 1'b0;
        mat_a_addr_i = '0;
        mat_b_addr_i = '0;
        mat_c_addr_i = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'h5a00_0000 ^ (i * 32'h0001_0003);
        end
        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        // idle after reset
        repeat (3) begin
            @(negedge clk);
            check_value("done_o idle", done_o, 1'b1);
            check_value("valid/ready outputs idle",
                        {arvalid_o, rready_o, awvalid_o, wvalid_o, bready_o}, 5'b0);
        end

        // first job without stalls and the rest with random stalls
        for (int job = 0; job < NUM_JOBS; job++) begin
            stall_en = (job > 0);
            load_job();
            run_job(job, ok);
            if (!ok) begin
                break;
            end
            compare_job(job);
        end

        $display("checks %0d, value errors %0d, timeouts %0d, assertion failures %0d",
                 check_cnt, error_cnt, timeout_cnt, DUT.u_sva.fail_cnt);
        if (error_cnt == 0 && timeout_cnt == 0 && DUT.u_sva.fail_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/dma_engine.sv ====
// DMA engine for the gemm tile accelerator
// reads A and B over AXI, packs beats into buffer words,
// starts the multiply and writes C back as one 16-beat burst
`timescale 1ns/1ps

module dma_engine
    import gemm_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // configuration
    input  axi_addr_t mat_a_addr_i,
    input  axi_addr_t mat_b_addr_i,
    input  axi_addr_t mat_c_addr_i,
    input  logic      start_i,
    output logic      done_o,
    // read address
    output logic      arvalid_o,
    input  logic      arready_i,
    output axi_addr_t araddr_o,
    output axi_id_t   arid_o,
    // read data
    input  logic      rvalid_i,
    output logic      rready_o,
    input  axi_id_t   rid_i,
    input  word_t     rdata_i,
    // write address
    output logic      awvalid_o,
    input  logic      awready_i,
    output axi_addr_t awaddr_o,
    // write data
    output logic      wvalid_o,
    input  logic      wready_i,
    output word_t     wdata_o,
    output logic      wlast_o,
    // write response
    input  logic      bvalid_i,
    output logic      bready_o,
    // buffer writes
    output logic      buf_a_wren_o,
    output buf_addr_t buf_a_waddr_o,
    output row_t      buf_a_wdata_o,
    output logic      buf_b_wren_o,
    output buf_addr_t buf_b_waddr_o,
    output row_t      buf_b_wdata_o,
    // multiply control
    output logic      mm_start_o,
    input  logic      mm_done_i,
    input  acc_t      accum_i [SA_WIDTH][SA_WIDTH]
);

    dma_state_t state;
    dma_state_t state_nx;

    // job addresses, held for the whole job
    axi_addr_t addr_a_q;
    axi_addr_t addr_b_q;
    axi_addr_t addr_c_q;

    // per-id packing, index 0 for A, 1 for B
    logic                          rx      [2];
    row_t                          shift_q [2];
    logic [$clog2(WORD_BEATS)-1:0] beat_q  [2];
    // words written so far, top bit means full
    logic [BUF_AW:0]               words_q [2];
    logic                          wren_q  [2];
    logic                          bufs_full;

    // write beat counter and the element it selects
    logic [$clog2(BURST_BEATS)-1:0] wcnt_q;
    logic                           last_beat;
    buf_addr_t                      c_row;
    buf_addr_t                      c_col;
    acc_t                           c_elem;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            rx[i] = rready_o && rvalid_i && (rid_i == axi_id_t'(i));
        end
    end

    assign bufs_full = words_q[ID_A][BUF_AW] && words_q[ID_B][BUF_AW];
    assign last_beat = (wcnt_q == BURST_BEATS - 1);

    // next state
    always_comb begin
        state_nx = state;
        case (state)
            DMA_IDLE: begin
                if (start_i) begin
                    state_nx = DMA_ADDR_A;
                end
            end
            DMA_ADDR_A: begin
                if (arready_i) begin
                    state_nx = DMA_ADDR_B;
                end
            end
            DMA_ADDR_B: begin
                if (arready_i) begin
                    state_nx = DMA_LOAD;
                end
            end
            DMA_LOAD: begin
                if (bufs_full) begin
                    state_nx = DMA_WAIT_MM;
                end
            end
            DMA_WAIT_MM: begin
                if (mm_done_i) begin
                    state_nx = DMA_ADDR_C;
                end
            end
            DMA_ADDR_C: begin
                if (awready_i) begin
                    state_nx = DMA_WRITE_C;
                end
            end
            DMA_WRITE_C: begin
                if (wready_i && last_beat) begin
                    state_nx = DMA_WAIT_B;
                end
            end
            DMA_WAIT_B: begin
                if (bvalid_i) begin
                    state_nx = DMA_IDLE;
                end
            end
            default: begin
                state_nx = DMA_IDLE;
            end
        endcase
    end

    // control registers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= DMA_IDLE;
            wcnt_q <= '0;
            for (int i = 0; i < 2; i++) begin
                beat_q[i]  <= '0;
                words_q[i] <= '0;
                wren_q[i]  <= 1'b0;
            end
        end else begin
            state <= state_nx;
            for (int i = 0; i < 2; i++) begin
                wren_q[i] <= 1'b0;
                if (state == DMA_IDLE && start_i) begin
                    beat_q[i]  <= '0;
                    words_q[i] <= '0;
                end else begin
                    if (rx[i]) begin
                        beat_q[i] <= beat_q[i] + 1'b1;
                        // fourth beat of a group, write the word next cycle
                        if (beat_q[i] == WORD_BEATS - 1) begin
                            wren_q[i] <= 1'b1;
                        end
                    end
                    if (wren_q[i]) begin
                        words_q[i] <= words_q[i] + 1'b1;
                    end
                end
            end
            if (state == DMA_ADDR_C) begin
                wcnt_q <= '0;
            end else if (wvalid_o && wready_i) begin
                wcnt_q <= wcnt_q + 1'b1;
            end
        end
    end

    // job addresses and beat packing
    always_ff @(posedge clk) begin
        if (state == DMA_IDLE && start_i) begin
            addr_a_q <= mat_a_addr_i;
            addr_b_q <= mat_b_addr_i;
            addr_c_q <= mat_c_addr_i;
        end
        for (int i = 0; i < 2; i++) begin
            // first beat of a group ends up in the top field
            if (rx[i]) begin
                shift_q[i] <= {shift_q[i][BUF_DW-DW-1:0], rdata_i};
            end
        end
    end

    assign done_o     = (state == DMA_IDLE);
    assign mm_start_o = (state == DMA_LOAD) && bufs_full;

    // read address, A first then B
    assign arvalid_o = (state == DMA_ADDR_A) || (state == DMA_ADDR_B);
    assign araddr_o  = (state == DMA_ADDR_B) ? addr_b_q : addr_a_q;
    assign arid_o    = (state == DMA_ADDR_B) ? ID_B : ID_A;
    assign rready_o  = (state == DMA_LOAD);

    assign buf_a_wren_o  = wren_q[ID_A];
    assign buf_a_waddr_o = words_q[ID_A][BUF_AW-1:0];
    assign buf_a_wdata_o = shift_q[ID_A];
    assign buf_b_wren_o  = wren_q[ID_B];
    assign buf_b_waddr_o = words_q[ID_B][BUF_AW-1:0];
    assign buf_b_wdata_o = shift_q[ID_B];

    // C in row-major order, low 32 bits of each sum
    assign c_row  = wcnt_q[3:2];
    assign c_col  = wcnt_q[1:0];
    assign c_elem = accum_i[c_row][c_col];

    assign awvalid_o = (state == DMA_ADDR_C);
    assign awaddr_o  = addr_c_q;
    assign wvalid_o  = (state == DMA_WRITE_C);
    assign wdata_o   = c_elem[DW-1:0];
    assign wlast_o   = wvalid_o && last_beat;
    assign bready_o  = (state == DMA_WAIT_B);

endmodule

// ==== verilog/gemm_pkg.sv ====
// shared widths, typedefs and localparams for the gemm tile accelerator
// state encodings of the DMA engine and the multiply engine
package gemm_pkg;

    // element and tile geometry
    localparam int DW          = 32;
    localparam int SA_WIDTH    = 4;
    localparam int BUF_AW      = 2;
    localparam int BUF_DW      = 128;
    localparam int BURST_BEATS = 16;
    // exact sum of four 32x32 signed products
    localparam int ACC_W       = 2 * DW + 2;
    // AXI beats packed into one buffer word
    localparam int WORD_BEATS  = BUF_DW / DW;

    typedef logic [DW-1:0]            word_t;
    typedef logic [BUF_DW-1:0]        row_t;
    typedef logic [BUF_AW-1:0]        buf_addr_t;
    typedef logic [31:0]              axi_addr_t;
    typedef logic [0:0]               axi_id_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    // read ids for the two source matrices
    localparam axi_id_t ID_A = 1'b0;
    localparam axi_id_t ID_B = 1'b1;

    typedef enum logic [2:0] {
        DMA_IDLE, DMA_ADDR_A, DMA_ADDR_B, DMA_LOAD,
        DMA_WAIT_MM, DMA_ADDR_C, DMA_WRITE_C, DMA_WAIT_B
    } dma_state_t;

    typedef enum logic [1:0] {
        MM_IDLE, MM_RUN, MM_DONE
    } mm_state_t;

endpackage

// ==== verilog/gemm_top.sv ====
// top level of the gemm tile accelerator
// DMA engine, tile buffers for A and B, multiply engine
`timescale 1ns/1ps

module gemm_top
    import gemm_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // configuration
    input  axi_addr_t mat_a_addr_i,
    input  axi_addr_t mat_b_addr_i,
    input  axi_addr_t mat_c_addr_i,
    input  logic      start_i,
    output logic      done_o,
    // read address
    output logic      arvalid_o,
    input  logic      arready_i,
    output axi_addr_t araddr_o,
    output axi_id_t   arid_o,
    // read data
    input  logic      rvalid_i,
    output logic      rready_o,
    input  axi_id_t   rid_i,
    input  word_t     rdata_i,
    // write address
    output logic      awvalid_o,
    input  logic      awready_i,
    output axi_addr_t awaddr_o,
    // write data
    output logic      wvalid_o,
    input  logic      wready_i,
    output word_t     wdata_o,
    output logic      wlast_o,
    // write response
    input  logic      bvalid_i,
    output logic      bready_o
);

    // buffer write side, from the DMA engine
    logic      buf_a_wren;
    buf_addr_t buf_a_waddr;
    row_t      buf_a_wdata;
    logic      buf_b_wren;
    buf_addr_t buf_b_waddr;
    row_t      buf_b_wdata;

    // buffer read side, shared address from the multiply engine
    buf_addr_t rd_addr;
    row_t      buf_a_rdata;
    row_t      buf_b_rdata;

    logic      mm_start;
    logic      mm_done;
    acc_t      accum [SA_WIDTH][SA_WIDTH];

    dma_engine u_dma (
        .clk           (clk),
        .rst_n         (rst_n),
        .mat_a_addr_i  (mat_a_addr_i),
        .mat_b_addr_i  (mat_b_addr_i),
        .mat_c_addr_i  (mat_c_addr_i),
        .start_i       (start_i),
        .done_o        (done_o),
        .arvalid_o     (arvalid_o),
        .arready_i     (arready_i),
        .araddr_o      (araddr_o),
        .arid_o        (arid_o),
        .rvalid_i      (rvalid_i),
        .rready_o      (rready_o),
        .rid_i         (rid_i),
        .rdata_i       (rdata_i),
        .awvalid_o     (awvalid_o),
        .awready_i     (awready_i),
        .awaddr_o      (awaddr_o),
        .wvalid_o      (wvalid_o),
        .wready_i      (wready_i),
        .wdata_o       (wdata_o),
        .wlast_o       (wlast_o),
        .bvalid_i      (bvalid_i),
        .bready_o      (bready_o),
        .buf_a_wren_o  (buf_a_wren),
        .buf_a_waddr_o (buf_a_waddr),
        .buf_a_wdata_o (buf_a_wdata),
        .buf_b_wren_o  (buf_b_wren),
        .buf_b_waddr_o (buf_b_waddr),
        .buf_b_wdata_o (buf_b_wdata),
        .mm_start_o    (mm_start),
        .mm_done_i     (mm_done),
        .accum_i       (accum)
    );

    // columns of A
    tile_buffer u_buf_a (
        .clk     (clk),
        .rst_n   (rst_n),
        .wren_i  (buf_a_wren),
        .waddr_i (buf_a_waddr),
        .wdata_i (buf_a_wdata),
        .raddr_i (rd_addr),
        .rdata_o (buf_a_rdata)
    );

    // rows of B
    tile_buffer u_buf_b (
        .clk     (clk),
        .rst_n   (rst_n),
        .wren_i  (buf_b_wren),
        .waddr_i (buf_b_waddr),
        .wdata_i (buf_b_wdata),
        .raddr_i (rd_addr),
        .rdata_o (buf_b_rdata)
    );

    mm_engine u_mm (
        .clk        (clk),
        .rst_n      (rst_n),
        .mm_start_i (mm_start),
        .a_row_i    (buf_a_rdata),
        .b_row_i    (buf_b_rdata),
        .rd_addr_o  (rd_addr),
        .mm_done_o  (mm_done),
        .accum_o    (accum)
    );

endmodule

// ==== verilog/mm_engine.sv ====
// multiply engine for one 4x4 tile
// steps both buffers over four words and sums the outer products
// column k of A times row k of B, exact signed accumulators
`timescale 1ns/1ps

module mm_engine
    import gemm_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      mm_start_i,
    input  row_t      a_row_i,
    input  row_t      b_row_i,
    output buf_addr_t rd_addr_o,
    output logic      mm_done_o,
    output acc_t      accum_o [SA_WIDTH][SA_WIDTH]
);

    mm_state_t state;
    buf_addr_t rd_addr_q;
    // buffer data on the inputs is a pair to accumulate
    logic      pair_vld_q;
    logic      done_q;

    acc_t                   acc_q [SA_WIDTH][SA_WIDTH];
    logic signed [DW-1:0]   a_el  [SA_WIDTH];
    logic signed [DW-1:0]   b_el  [SA_WIDTH];
    logic signed [2*DW-1:0] prod  [SA_WIDTH][SA_WIDTH];

    // element i sits in the i-th field from the top
    always_comb begin
        for (int i = 0; i < SA_WIDTH; i++) begin
            a_el[i] = a_row_i[BUF_DW-1-i*DW -: DW];
            b_el[i] = b_row_i[BUF_DW-1-i*DW -: DW];
        end
    end

    // sixteen signed products of one outer product
    always_comb begin
        for (int i = 0; i < SA_WIDTH; i++) begin
            for (int j = 0; j < SA_WIDTH; j++) begin
                prod[i][j] = a_el[i] * b_el[j];
            end
        end
    end

    // control
    // start -> four read cycles -> one drain cycle -> done
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= MM_IDLE;
            rd_addr_q  <= '0;
            pair_vld_q <= 1'b0;
            done_q     <= 1'b0;
        end else if (mm_start_i) begin
            state      <= MM_RUN;
            rd_addr_q  <= '0;
            pair_vld_q <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            // read data returns one cycle after the address
            pair_vld_q <= (state == MM_RUN);
            case (state)
                MM_RUN: begin
                    rd_addr_q <= rd_addr_q + 1'b1;
                    if (rd_addr_q == buf_addr_t'(SA_WIDTH - 1)) begin
                        state <= MM_DONE;
                    end
                end
                MM_DONE: begin
                    // last pair lands this cycle, done next one
                    if (pair_vld_q) begin
                        done_q <= 1'b1;
                    end
                end
                default: begin
                    done_q <= done_q;
                end
            endcase
        end
    end

    // accumulators, cleared by each new start
    always_ff @(posedge clk) begin
        for (int i = 0; i < SA_WIDTH; i++) begin
            for (int j = 0; j < SA_WIDTH; j++) begin
                if (mm_start_i) begin
                    acc_q[i][j] <= '0;
                end else if (pair_vld_q) begin
                    acc_q[i][j] <= acc_q[i][j] + prod[i][j];
                end
            end
        end
    end

    assign rd_addr_o = rd_addr_q;
    assign mm_done_o = done_q;
    assign accum_o   = acc_q;

endmodule

// ==== verilog/tile_buffer.sv ====
// tile buffer, four 128-bit words
// one write port, one read port with a cycle of latency
`timescale 1ns/1ps

module tile_buffer
    import gemm_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      wren_i,
    input  buf_addr_t waddr_i,
    input  row_t      wdata_i,
    input  buf_addr_t raddr_i,
    output row_t      rdata_o
);

    // one entry per buffer word
    row_t mem [SA_WIDTH];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < SA_WIDTH; i++) begin
                mem[i] <= '0;
            end
            rdata_o <= '0;
        end else begin
            if (wren_i) begin
                mem[waddr_i] <= wdata_i;
            end
            // registered read, old data on a same-address write
            rdata_o <= mem[raddr_i];
        end
    end

endmodule
